//--- tiny900_params.svh
`ifndef TINY900_PARAMS_SVH
`define TINY900_PARAMS_SVH

// RAM byte address width
`define TINY_AW 24

// Data word and register width
`define TINY_DW 16

// Register count and register index width
`define TINY_NREG 8
`define TINY_RSEL 3

// Dump port address and data width
`define TINY_DMPW 8

`endif

//--- tiny900_isa_pkg.sv
package tiny900_isa_pkg;

    // Opcode sits in bits 15 to 12 of the instruction word
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_LD   = 4'h2,
        OP_ADD  = 4'h3,
        OP_SUB  = 4'h4,
        OP_AND  = 4'h5,
        OP_OR   = 4'h6,
        OP_XOR  = 4'h7,
        OP_CP   = 4'h8,
        OP_LDM  = 4'h9,
        OP_STM  = 4'ha,
        OP_JP   = 4'hb,
        OP_JRZ  = 4'hc,
        OP_HALT = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_t;

    // Bit positions in the flag word
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_S = 2;

endpackage

//--- tiny900_bus_pkg.sv
package tiny900_bus_pkg;

    // Byte write enables, bit 1 for the high byte
    typedef logic [1:0] ram_be_t;

    localparam ram_be_t BE_NONE = 2'b00;
    localparam ram_be_t BE_WORD = 2'b11;

    // Why the RAM is being accessed
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        FETCH   = 2'd1,
        DATA_RD = 2'd2,
        DATA_WR = 2'd3
    } ram_kind_t;

endpackage

//--- tiny900_ctrl.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_ctrl(
    input                                   clk,
    input                                   rst,
    input                                   cen,

    input        [`TINY_DW-1:0]             instr,
    input                                   ram_rdy,
    input        [2:0]                      flags,

    output logic                            ram_ren,
    output logic                            ram_wen,
    output tiny900_bus_pkg::ram_kind_t      ram_kind,
    output logic                            addr_sel,

    output logic [`TINY_RSEL-1:0]           rd_a,
    output logic [`TINY_RSEL-1:0]           rd_b,
    output logic [`TINY_RSEL-1:0]           wr_sel,
    output logic                            wr_en,
    output logic                            wr_src_mem,

    output tiny900_isa_pkg::alu_op_t        alu_op,
    output logic                            flag_we,
    output logic                            use_imm,

    output logic                            pc_inc,
    output logic                            pc_load,
    output logic                            pc_rel,
    output logic [7:0]                      rel_off,
    output logic                            halted
);

typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_IMM,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALTED
} state_t;

state_t                     state;
logic                       sent;
logic [`TINY_DW-1:0]        ir;
tiny900_isa_pkg::opcode_t   op;
logic                       fetching, mem_rd, mem_wr;
logic                       alu_wr, alu_fl;

assign op       = tiny900_isa_pkg::opcode_t'(ir[15:12]);
assign fetching = state == S_FETCH || state == S_IMM;
assign mem_rd   = state == S_MEM && op == tiny900_isa_pkg::OP_LDM;
assign mem_wr   = state == S_MEM && op == tiny900_isa_pkg::OP_STM;

// One request per phase, the next only after ram_rdy
assign ram_ren  = !sent && (fetching || mem_rd);
assign ram_wen  = !sent && mem_wr;
assign addr_sel = state == S_MEM;

always_comb begin
    if (fetching)
        ram_kind = tiny900_bus_pkg::FETCH;
    else if (mem_rd)
        ram_kind = tiny900_bus_pkg::DATA_RD;
    else if (mem_wr)
        ram_kind = tiny900_bus_pkg::DATA_WR;
    else
        ram_kind = tiny900_bus_pkg::IDLE;
end

// LDM takes its address from the source field, STM from the destination field
assign rd_a   = op == tiny900_isa_pkg::OP_LDM ? ir[8:6] : ir[11:9];
assign rd_b   = ir[8:6];
assign wr_sel = ir[11:9];

always_comb begin
    alu_op = tiny900_isa_pkg::ALU_PASS;
    alu_wr = 1'b0;
    alu_fl = 1'b0;
    case (op)
        tiny900_isa_pkg::OP_LDI,
        tiny900_isa_pkg::OP_LD: alu_wr = 1'b1;
        tiny900_isa_pkg::OP_ADD: begin
            alu_op = tiny900_isa_pkg::ALU_ADD;
            alu_wr = 1'b1;
            alu_fl = 1'b1;
        end
        tiny900_isa_pkg::OP_SUB: begin
            alu_op = tiny900_isa_pkg::ALU_SUB;
            alu_wr = 1'b1;
            alu_fl = 1'b1;
        end
        tiny900_isa_pkg::OP_AND: begin
            alu_op = tiny900_isa_pkg::ALU_AND;
            alu_wr = 1'b1;
            alu_fl = 1'b1;
        end
        tiny900_isa_pkg::OP_OR: begin
            alu_op = tiny900_isa_pkg::ALU_OR;
            alu_wr = 1'b1;
            alu_fl = 1'b1;
        end
        tiny900_isa_pkg::OP_XOR: begin
            alu_op = tiny900_isa_pkg::ALU_XOR;
            alu_wr = 1'b1;
            alu_fl = 1'b1;
        end
        // Compare is a subtraction that only keeps the flags
        tiny900_isa_pkg::OP_CP: begin
            alu_op = tiny900_isa_pkg::ALU_SUB;
            alu_fl = 1'b1;
        end
        default: alu_wr = 1'b0;
    endcase
end

assign wr_en      = (state == S_EXEC && alu_wr) || state == S_WB;
assign wr_src_mem = state == S_WB;
assign flag_we    = state == S_EXEC && alu_fl;
assign use_imm    = op == tiny900_isa_pkg::OP_LDI;

// The immediate word stays on mem_data until the next access
assign pc_inc  = fetching && ram_rdy;
assign pc_load = state == S_EXEC && op == tiny900_isa_pkg::OP_JP;
assign pc_rel  = state == S_EXEC && op == tiny900_isa_pkg::OP_JRZ
                 && flags[tiny900_isa_pkg::FLAG_Z];
assign rel_off = ir[7:0];
assign halted  = state == S_HALTED;

always_ff @(posedge clk) begin
    if (rst) begin
        // Leave reset decoding a NOP so all strobes start low
        state <= S_DECODE;
        sent  <= 1'b0;
        ir    <= '0;
    end else if (cen) begin
        if (ram_rdy)
            sent <= 1'b0;
        else if (ram_ren || ram_wen)
            sent <= 1'b1;
        case (state)
            S_FETCH: begin
                if (ram_rdy) begin
                    ir    <= instr;
                    state <= S_DECODE;
                end
            end
            S_DECODE: begin
                case (op)
                    tiny900_isa_pkg::OP_NOP:  state <= S_FETCH;
                    tiny900_isa_pkg::OP_HALT: state <= S_HALTED;
                    tiny900_isa_pkg::OP_LDI,
                    tiny900_isa_pkg::OP_JP:   state <= S_IMM;
                    default:                  state <= S_EXEC;
                endcase
            end
            S_IMM: begin
                if (ram_rdy)
                    state <= S_EXEC;
            end
            S_EXEC: begin
                if (op == tiny900_isa_pkg::OP_LDM || op == tiny900_isa_pkg::OP_STM)
                    state <= S_MEM;
                else
                    state <= S_FETCH;
            end
            S_MEM: begin
                if (ram_rdy)
                    state <= mem_rd ? S_WB : S_FETCH;
            end
            S_WB:     state <= S_FETCH;
            S_HALTED: state <= S_HALTED;
            default:  state <= S_FETCH;
        endcase
    end
end

assert property (@(posedge clk) disable iff (rst) !(ram_ren && ram_wen))
    else $error("read and write requested together");

endmodule

//--- tiny900_regs.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_regs(
    input                               clk,
    input                               rst,
    input                               cen,

    input        [`TINY_RSEL-1:0]       rd_a,
    input        [`TINY_RSEL-1:0]       rd_b,
    input        [`TINY_RSEL-1:0]       wr_sel,
    input                               wr_en,
    input                               wr_src_mem,
    input        [`TINY_DW-1:0]         wr_data,
    input        [`TINY_DW-1:0]         mem_data,
    input        [2:0]                  flags_in,

    output       [`TINY_DW-1:0]         reg_a,
    output       [`TINY_DW-1:0]         reg_b,
    // Register dump
    input        [`TINY_DMPW-1:0]       dmp_addr,
    output logic [`TINY_DMPW-1:0]       dmp_din
);

logic [`TINY_DW-1:0] rf [`TINY_NREG];
logic [`TINY_DW-1:0] dmp_word;

assign reg_a = rf[rd_a];
assign reg_b = rf[rd_b];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `TINY_NREG; i++)
            rf[i] <= '0;
    end else if (cen && wr_en) begin
        rf[wr_sel] <= wr_src_mem ? mem_data : wr_data;
    end
end

// Byte 2n is the low half of register n, 2n+1 the high half
assign dmp_word = rf[dmp_addr[`TINY_RSEL:1]];

always_comb begin
    if (dmp_addr < 2 * `TINY_NREG)
        dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
    else if (dmp_addr == 2 * `TINY_NREG)
        dmp_din = {5'd0, flags_in};
    else
        dmp_din = '0;
end

endmodule

//--- tiny900_alu.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_alu(
    input                               clk,
    input                               rst,
    input                               cen,

    input  tiny900_isa_pkg::alu_op_t    alu_op,
    input        [`TINY_DW-1:0]         op_a,
    input        [`TINY_DW-1:0]         op_b,
    input        [`TINY_DW-1:0]         imm,
    input                               use_imm,
    input                               flag_we,

    output       [`TINY_DW-1:0]         result,
    output logic [2:0]                  flags
);

logic [`TINY_DW-1:0] opnd;
// One extra bit keeps the carry or borrow
logic [`TINY_DW:0]   full;

assign opnd   = use_imm ? imm : op_b;
assign result = full[`TINY_DW-1:0];

always_comb begin
    case (alu_op)
        tiny900_isa_pkg::ALU_ADD: full = {1'b0, op_a} + {1'b0, opnd};
        tiny900_isa_pkg::ALU_SUB: full = {1'b0, op_a} - {1'b0, opnd};
        tiny900_isa_pkg::ALU_AND: full = {1'b0, op_a & opnd};
        tiny900_isa_pkg::ALU_OR:  full = {1'b0, op_a | opnd};
        tiny900_isa_pkg::ALU_XOR: full = {1'b0, op_a ^ opnd};
        default:                  full = {1'b0, opnd};
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        flags <= '0;
    end else if (cen && flag_we) begin
        flags[tiny900_isa_pkg::FLAG_Z] <= result == '0;
        flags[tiny900_isa_pkg::FLAG_C] <= full[`TINY_DW];
        flags[tiny900_isa_pkg::FLAG_S] <= result[`TINY_DW-1];
    end
end

// Loads and moves must never disturb the flags
assert property (@(posedge clk) disable iff (rst)
    flag_we |-> alu_op != tiny900_isa_pkg::ALU_PASS)
    else $error("flag write on a pass operation");

endmodule

//--- tiny900_pc.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_pc(
    input                               clk,
    input                               rst,
    input                               cen,

    input                               pc_inc,
    input                               pc_load,
    input                               pc_rel,
    input        [`TINY_DW-1:0]         load_val,
    input        [7:0]                  rel_off,

    output logic [`TINY_AW-1:0]         pc
);

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (cen) begin
        // Absolute jump first, then the relative branch, then the step
        if (pc_load)
            pc <= {{(`TINY_AW - `TINY_DW){1'b0}}, load_val};
        else if (pc_rel)
            pc <= pc + {{(`TINY_AW - 9){rel_off[7]}}, rel_off, 1'b0};
        else if (pc_inc)
            pc <= pc + `TINY_AW'd2;
    end
end

assert property (@(posedge clk) disable iff (rst) !pc[0])
    else $error("odd program counter");

endmodule

//--- tiny900_ramctl.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_ramctl(
    input                               clk,
    input                               rst,
    input                               cen,

    input                               ram_ren,
    input                               ram_wen,
    input  tiny900_bus_pkg::ram_kind_t  ram_kind,
    input                               addr_sel,
    input        [`TINY_AW-1:0]         pc,
    input        [`TINY_DW-1:0]         reg_addr,
    input        [`TINY_DW-1:0]         wr_word,

    // RAM interface
    output       [`TINY_AW-1:0]         ram_addr,
    input        [`TINY_DW-1:0]         ram_dout,
    output       [`TINY_DW-1:0]         ram_din,
    output tiny900_bus_pkg::ram_be_t    ram_we,

    output logic [`TINY_DW-1:0]         mem_data,
    output logic                        ram_rdy
);

logic                           ph_addr, ph_data;
logic [`TINY_AW-1:0]            addr_q;
logic [`TINY_DW-1:0]            din_q;
tiny900_bus_pkg::ram_kind_t     kind_q;

assign ram_addr = addr_q;
assign ram_din  = din_q;

always_ff @(posedge clk) begin
    if (cen && (ram_ren || ram_wen)) begin
        addr_q <= addr_sel ? {{(`TINY_AW - `TINY_DW){1'b0}}, reg_addr} : pc;
        din_q  <= wr_word;
        kind_q <= ram_kind;
    end
    // A write leaves the last word read in place
    if (cen && ph_data && kind_q != tiny900_bus_pkg::DATA_WR)
        mem_data <= ram_dout;
end

// Address cycle, then data cycle, then the done pulse
always_ff @(posedge clk) begin
    if (rst) begin
        ph_addr <= 1'b0;
        ph_data <= 1'b0;
        ram_rdy <= 1'b0;
        ram_we  <= tiny900_bus_pkg::BE_NONE;
    end else if (cen) begin
        ph_addr <= ram_ren || ram_wen;
        ph_data <= ph_addr;
        ram_rdy <= ph_data;
        ram_we  <= ram_wen ? tiny900_bus_pkg::BE_WORD : tiny900_bus_pkg::BE_NONE;
    end
end

assert property (@(posedge clk) disable iff (rst)
    cen && (ram_ren || ram_wen) |-> !(ph_addr || ph_data))
    else $error("RAM request while another is pending");

endmodule

//--- tiny900.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900(
    input                               clk,
    input                               rst,
    input                               cen,

    output     [`TINY_AW-1:0]           ram_addr,
    input      [`TINY_DW-1:0]           ram_dout,
    output     [`TINY_DW-1:0]           ram_din,
    output tiny900_bus_pkg::ram_be_t    ram_we,
    // Register dump
    input      [`TINY_DMPW-1:0]         dmp_addr,
    output     [`TINY_DMPW-1:0]         dmp_din,
    output                              halted
);

// Memory controller
wire                            ram_ren, ram_wen, ram_rdy, addr_sel;
tiny900_bus_pkg::ram_kind_t     ram_kind;
wire [`TINY_DW-1:0]             mem_data;

// Register bank
wire [`TINY_RSEL-1:0]           rd_a, rd_b, wr_sel;
wire                            wr_en, wr_src_mem;
wire [`TINY_DW-1:0]             reg_a, reg_b;

// ALU control
tiny900_isa_pkg::alu_op_t       alu_op;
wire                            flag_we, use_imm;
wire [`TINY_DW-1:0]             result;
wire [2:0]                      flags;

// PC control
wire [`TINY_AW-1:0]             pc;
wire                            pc_inc, pc_load, pc_rel;
wire [7:0]                      rel_off;

tiny900_ctrl u_ctrl(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .instr          ( mem_data          ),
    .ram_rdy        ( ram_rdy           ),
    .flags          ( flags             ),
    .ram_ren        ( ram_ren           ),
    .ram_wen        ( ram_wen           ),
    .ram_kind       ( ram_kind          ),
    .addr_sel       ( addr_sel          ),
    .rd_a           ( rd_a              ),
    .rd_b           ( rd_b              ),
    .wr_sel         ( wr_sel            ),
    .wr_en          ( wr_en             ),
    .wr_src_mem     ( wr_src_mem        ),
    .alu_op         ( alu_op            ),
    .flag_we        ( flag_we           ),
    .use_imm        ( use_imm           ),
    .pc_inc         ( pc_inc            ),
    .pc_load        ( pc_load           ),
    .pc_rel         ( pc_rel            ),
    .rel_off        ( rel_off           ),
    .halted         ( halted            )
);

tiny900_regs u_regs(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .rd_a           ( rd_a              ),
    .rd_b           ( rd_b              ),
    .wr_sel         ( wr_sel            ),
    .wr_en          ( wr_en             ),
    .wr_src_mem     ( wr_src_mem        ),
    .wr_data        ( result            ),
    .mem_data       ( mem_data          ),
    .flags_in       ( flags             ),
    .reg_a          ( reg_a             ),
    .reg_b          ( reg_b             ),
    .dmp_addr       ( dmp_addr          ),
    .dmp_din        ( dmp_din           )
);

// Immediates come straight from the last word read
tiny900_alu u_alu(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .alu_op         ( alu_op            ),
    .op_a           ( reg_a             ),
    .op_b           ( reg_b             ),
    .imm            ( mem_data          ),
    .use_imm        ( use_imm           ),
    .flag_we        ( flag_we           ),
    .result         ( result            ),
    .flags          ( flags             )
);

tiny900_pc u_pc(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .pc_inc         ( pc_inc            ),
    .pc_load        ( pc_load           ),
    .pc_rel         ( pc_rel            ),
    .load_val       ( mem_data          ),
    .rel_off        ( rel_off           ),
    .pc             ( pc                )
);

tiny900_ramctl u_ramctl(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .ram_ren        ( ram_ren           ),
    .ram_wen        ( ram_wen           ),
    .ram_kind       ( ram_kind          ),
    .addr_sel       ( addr_sel          ),
    .pc             ( pc                ),
    .reg_addr       ( reg_a             ),
    .wr_word        ( reg_b             ),
    .ram_addr       ( ram_addr          ),
    .ram_dout       ( ram_dout          ),
    .ram_din        ( ram_din           ),
    .ram_we         ( ram_we            ),
    .mem_data       ( mem_data          ),
    .ram_rdy        ( ram_rdy           )
);

endmodule

//--- tiny900_tb.sv
`timescale 1ns/1ps
`include "tiny900_params.svh"

module tiny900_tb;

// Worst case per run: reset, 20 instructions of up to 12 cycles each (doubled
// for the cen toggling run) and a 17-byte register dump, for 7 program runs
localparam int RUN_CYCLES = 10 + 2 * 20 * 12 + 2 * 17 + 4;
localparam int MAX_CYCLES = 7 * RUN_CYCLES;

logic                   clk = 1'b0;
logic                   rst = 1'b1;
logic                   cen = 1'b1;
logic [`TINY_DMPW-1:0]  dmp_addr = '0;
logic [`TINY_DW-1:0]    ram_dout = '0;
wire  [`TINY_AW-1:0]    ram_addr;
wire  [`TINY_DW-1:0]    ram_din;
wire  [1:0]             ram_we;
wire  [`TINY_DMPW-1:0]  dmp_din;
wire                    halted;

logic [7:0]             ram [0:65535];
logic [15:0]            prog [$];
logic                   cen_rand = 1'b0;
int unsigned            cycles = 0;
int                     errors = 0;
int                     pass_count = 0;
int                     fail_count = 0;

logic [15:0]            got_reg [`TINY_NREG];
logic [15:0]            exp_reg [`TINY_NREG];
logic [15:0]            arith_ref [`TINY_NREG];
logic [2:0]             got_flags, exp_flags, arith_ref_flags;
logic [15:0]            a_val, b_val;

tiny900 dut(
    .clk        ( clk       ),
    .rst        ( rst       ),
    .cen        ( cen       ),
    .ram_addr   ( ram_addr  ),
    .ram_dout   ( ram_dout  ),
    .ram_din    ( ram_din   ),
    .ram_we     ( ram_we    ),
    .dmp_addr   ( dmp_addr  ),
    .dmp_din    ( dmp_din   ),
    .halted     ( halted    )
);

always #20 clk = ~clk;

// Little-endian RAM, word data one enabled cycle after the address
always @(posedge clk) begin
    if (cen) begin
        ram_dout <= {ram[{ram_addr[15:1], 1'b1}], ram[{ram_addr[15:1], 1'b0}]};
        if (ram_we[0])
            ram[{ram_addr[15:1], 1'b0}] <= ram_din[7:0];
        if (ram_we[1])
            ram[{ram_addr[15:1], 1'b1}] <= ram_din[15:8];
    end
end

always @(posedge clk) begin
    if (cen_rand)
        cen <= ($urandom & 1) != 0;
    else
        cen <= 1'b1;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout: CPU did not finish within %0d clock cycles", cycles);
        $display("Test failed");
        $finish;
    end
end

function automatic logic [7:0] fill_byte(logic [15:0] a);
    return a[7:0] ^ {a[14:8], a[15]} ^ 8'h3c;
endfunction

function automatic logic [15:0] reg_op(tiny900_isa_pkg::opcode_t op, int rd, int rs);
    return {op, 3'(rd), 3'(rs), 6'd0};
endfunction

// Z, C and S as the ALU is meant to store them
function automatic logic [2:0] flags_from(logic [15:0] res, logic carry);
    logic [2:0] f;
    f = '0;
    f[tiny900_isa_pkg::FLAG_Z] = res == 16'h0;
    f[tiny900_isa_pkg::FLAG_C] = carry;
    f[tiny900_isa_pkg::FLAG_S] = res[15];
    return f;
endfunction

task automatic load_imm(int rd, logic [15:0] val);
    prog.push_back(reg_op(tiny900_isa_pkg::OP_LDI, rd, 0));
    prog.push_back(val);
endtask

task automatic jump_to(logic [15:0] target);
    prog.push_back({tiny900_isa_pkg::OP_JP, 12'd0});
    prog.push_back(target);
endtask

// Offset counts words from the instruction after the branch
task automatic branch_if_zero(logic [7:0] off);
    prog.push_back({tiny900_isa_pkg::OP_JRZ, 4'd0, off});
endtask

task automatic halt_here();
    prog.push_back({tiny900_isa_pkg::OP_HALT, 12'd0});
endtask

task automatic load_program();
    for (int i = 0; i < 65536; i++)
        ram[i] = fill_byte(16'(i));
    foreach (prog[i]) begin
        ram[2 * i]     = prog[i][7:0];
        ram[2 * i + 1] = prog[i][15:8];
    end
endtask

task automatic read_byte(input logic [7:0] a, output logic [7:0] d);
    @(posedge clk);
    dmp_addr <= a;
    @(negedge clk);
    d = dmp_din;
endtask

task automatic dump_state();
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] fl;
    for (int n = 0; n < `TINY_NREG; n++) begin
        read_byte(8'(2 * n), lo);
        read_byte(8'(2 * n + 1), hi);
        got_reg[n] = {hi, lo};
    end
    read_byte(8'(2 * `TINY_NREG), fl);
    got_flags = fl[2:0];
endtask

task automatic run_program(input bit toggle);
    load_program();
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    cen_rand <= toggle;
    do
        @(negedge clk);
    while (!halted);
    @(posedge clk);
    cen_rand <= 1'b0;
    dump_state();
endtask

task automatic clear_expect();
    for (int n = 0; n < `TINY_NREG; n++)
        exp_reg[n] = '0;
    exp_flags = '0;
endtask

task automatic compare_dump();
    for (int n = 0; n < `TINY_NREG; n++) begin
        if (got_reg[n] !== exp_reg[n]) begin
            $display("** Error at %0d ns: r%0d = %h, expected %h",
                     $time, n, got_reg[n], exp_reg[n]);
            errors++;
        end
    end
    if (got_flags !== exp_flags) begin
        $display("** Error at %0d ns: flags = %b, expected %b", $time, got_flags, exp_flags);
        errors++;
    end
endtask

task automatic finish_test(input string name);
    if (errors == 0) begin
        pass_count++;
        $display("%s: PASS", name);
    end else begin
        fail_count++;
        $display("%s: FAIL, %0d mismatches", name, errors);
    end
    errors = 0;
endtask

task automatic reset_halt_test();
    prog.delete();
    halt_here();
    run_program(1'b0);
    clear_expect();
    compare_dump();
    finish_test("reset and halt");
endtask

// Each operation works on a copy of r0, the last ADD sets the flags
task automatic arith_prog();
    prog.delete();
    load_imm(0, a_val);
    load_imm(1, b_val);
    for (int n = 2; n < `TINY_NREG; n++)
        prog.push_back(reg_op(tiny900_isa_pkg::OP_LD, n, 0));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_ADD, 2, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_SUB, 3, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_AND, 4, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_OR, 5, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_XOR, 6, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_ADD, 7, 1));
    halt_here();
endtask

task automatic arith_expect();
    logic [16:0] sum;
    sum = {1'b0, a_val} + {1'b0, b_val};
    exp_reg[0] = a_val;
    exp_reg[1] = b_val;
    exp_reg[2] = sum[15:0];
    exp_reg[3] = a_val - b_val;
    exp_reg[4] = a_val & b_val;
    exp_reg[5] = a_val | b_val;
    exp_reg[6] = a_val ^ b_val;
    exp_reg[7] = sum[15:0];
    exp_flags  = flags_from(sum[15:0], sum[16]);
endtask

task automatic arith_test();
    a_val = 16'($urandom);
    b_val = 16'($urandom);
    arith_prog();
    run_program(1'b0);
    arith_expect();
    compare_dump();
    arith_ref = got_reg;
    arith_ref_flags = got_flags;
    finish_test("arithmetic and logic");
endtask

task automatic compare_test();
    logic [15:0] x;
    logic [15:0] y;
    x = 16'($urandom_range(32'h7fff, 32'h0));
    y = x + 16'($urandom_range(32'h7fff, 32'h1));
    // Equal operands
    prog.delete();
    load_imm(0, x);
    load_imm(1, x);
    prog.push_back(reg_op(tiny900_isa_pkg::OP_CP, 0, 1));
    halt_here();
    run_program(1'b0);
    clear_expect();
    exp_reg[0] = x;
    exp_reg[1] = x;
    exp_flags  = flags_from(16'h0, 1'b0);
    compare_dump();
    // Smaller first operand borrows
    prog.delete();
    load_imm(0, x);
    load_imm(1, y);
    prog.push_back(reg_op(tiny900_isa_pkg::OP_CP, 0, 1));
    halt_here();
    run_program(1'b0);
    exp_reg[1] = y;
    exp_flags  = flags_from(x - y, x < y);
    compare_dump();
    finish_test("compare");
endtask

task automatic memory_test();
    logic [15:0] addr;
    logic [15:0] data;
    addr = 16'($urandom_range(32'h7ffe, 32'h0080)) << 1;
    data = 16'($urandom);
    prog.delete();
    load_imm(0, addr);
    load_imm(1, data);
    prog.push_back(reg_op(tiny900_isa_pkg::OP_STM, 0, 1));
    prog.push_back(reg_op(tiny900_isa_pkg::OP_LDM, 2, 0));
    halt_here();
    run_program(1'b0);
    clear_expect();
    exp_reg[0] = addr;
    exp_reg[1] = data;
    exp_reg[2] = data;
    compare_dump();
    if ({ram[addr + 16'd1], ram[addr]} !== data) begin
        $display("** Error at %0d ns: RAM word at %h = %h, expected %h",
                 $time, addr, {ram[addr + 16'd1], ram[addr]}, data);
        errors++;
    end
    if (ram[addr + 16'd2] !== fill_byte(addr + 16'd2)) begin
        $display("** Error at %0d ns: RAM byte at %h was overwritten", $time, addr + 16'd2);
        errors++;
    end
    finish_test("store and load");
endtask

task automatic branch_test();
    prog.delete();
    load_imm(0, 16'd5);                                 // 0
    load_imm(1, 16'd5);                                 // 4
    prog.push_back(reg_op(tiny900_isa_pkg::OP_CP, 0, 1));   // 8, Z set
    branch_if_zero(8'd2);                               // 10, taken to 16
    load_imm(2, 16'hbad1);                              // 12
    prog.push_back(reg_op(tiny900_isa_pkg::OP_CP, 0, 4));   // 16, Z clear
    branch_if_zero(8'd2);                               // 18, falls through
    load_imm(3, 16'h0c3c);                              // 20
    jump_to(16'd32);                                    // 24
    load_imm(5, 16'hbad3);                              // 28
    jump_to(16'd42);                                    // 32
    load_imm(6, 16'h600d);                              // 36, backward target
    halt_here();                                        // 40
    prog.push_back(reg_op(tiny900_isa_pkg::OP_CP, 0, 1));   // 42, Z set
    branch_if_zero(8'hfb);                              // 44, back to 36
    load_imm(7, 16'hbad5);                              // 46
    halt_here();                                        // 50
    run_program(1'b0);
    clear_expect();
    exp_reg[0] = 16'd5;
    exp_reg[1] = 16'd5;
    exp_reg[3] = 16'h0c3c;
    exp_reg[6] = 16'h600d;
    exp_flags  = flags_from(16'h0, 1'b0);
    compare_dump();
    finish_test("branches");
endtask

task automatic cen_test();
    arith_prog();
    run_program(1'b1);
    arith_expect();
    compare_dump();
    for (int n = 0; n < `TINY_NREG; n++) begin
        if (got_reg[n] !== arith_ref[n]) begin
            $display("** Error at %0d ns: r%0d = %h, run with cen high gave %h",
                     $time, n, got_reg[n], arith_ref[n]);
            errors++;
        end
    end
    if (got_flags !== arith_ref_flags) begin
        $display("** Error at %0d ns: flags differ from the run with cen high", $time);
        errors++;
    end
    finish_test("clock enable");
endtask

initial begin
    void'($urandom(48));
    reset_halt_test();
    arith_test();
    compare_test();
    memory_test();
    branch_test();
    cen_test();
    $display("Tests passed: %0d, tests with errors: %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count == 6) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

//--- project.f
+incdir+.
tiny900_isa_pkg.sv
tiny900_bus_pkg.sv
tiny900_ctrl.sv
tiny900_regs.sv
tiny900_alu.sv
tiny900_pc.sv
tiny900_ramctl.sv
tiny900.sv
tiny900_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the tiny900 testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tiny900_tb -f project.f -o tiny900_sim
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

./obj_dir/tiny900_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
exit 1
